// ==== rtl/rvfi_cmp_pkg.sv ====
// RVFI step-and-compare checker package
// shared retirement record, compared field indices, mismatch record
// and the state encoding of the mismatch log

package rvfi_cmp_pkg;

  // one RVFI retirement as seen from either the core or the reference model
  typedef struct packed {
    logic [31:0] pc_rdata;
    logic [31:0] insn;
    logic        trap;
    logic        halt;
    logic        dbg_mode;
    logic [2:0]  dbg;
    logic [1:0]  nmip;
    logic        intr;
    logic [1:0]  mode;
    logic [4:0]  rd1_addr;
    logic [31:0] rd1_wdata;
    logic [31:0] mem_addr;
    // low nibble is the first access, high nibble a second access
    logic [7:0]  mem_rmask;
    logic [7:0]  mem_wmask;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
  } rvfi_retire_t;

  // compared fields, the value is the bit index in the mismatch vector
  typedef enum logic [3:0] {
    F_PC        = 4'd0,
    F_INSN      = 4'd1,
    F_TRAP      = 4'd2,
    F_HALT      = 4'd3,
    F_DBG       = 4'd4,
    F_DBG_MODE  = 4'd5,
    F_NMIP      = 4'd6,
    F_INTR      = 4'd7,
    F_MODE      = 4'd8,
    F_RD_ADDR   = 4'd9,
    F_RD_WDATA  = 4'd10,
    F_MEM_RMASK = 4'd11,
    F_MEM_WMASK = 4'd12,
    F_MEM_ADDR  = 4'd13,
    F_MEM_DATA  = 4'd14
  } cmp_field_e;

  localparam int unsigned NUM_FIELDS = 15;

  // one bit per compared field
  typedef logic [NUM_FIELDS-1:0] cmp_mask_t;

  // record of a failing retirement, taken from the core side
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
    cmp_mask_t   mask;
  } mismatch_t;

  // mismatch log FSM
  typedef enum logic {
    LOG_CLEAN  = 1'b0,
    LOG_FAILED = 1'b1
  } log_state_e;

endpackage

// ==== rtl/rvfi_retire_fifo.sv ====
// RVFI retirement FIFO
// holds core retirements until the reference model retires the same
// instruction, then hands out the matching core entry for comparison

`timescale 1ns/1ns

module rvfi_retire_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                       rvfi_core,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  rvfi_cmp_pkg::rvfi_retire_t push_data_i,
  input  logic                       pop_i,
  output logic                       pair_valid_o,
  output rvfi_cmp_pkg::rvfi_retire_t pair_data_o,
  output logic                       overflow_o,
  output logic                       order_err_o
);

  import rvfi_cmp_pkg::*;

  // DEPTH is a power of two, so the pointers wrap on their own
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  rvfi_retire_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic empty;
  logic full;
  logic bypass;
  logic do_pop;
  logic do_push;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(DEPTH));

  // empty fifo with both strobes: the new entry goes straight to the compare
  assign bypass = push_i && pop_i && empty;
  assign do_pop = pop_i && !empty;

  // a pop in the same cycle frees a slot even when full
  assign do_push = push_i && !bypass && (!full || do_pop);

  assign pair_valid_o = do_pop || bypass;
  assign pair_data_o  = empty ? push_data_i : mem_q[rd_ptr_q];

  always_ff @(posedge rvfi_core) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // sticky protocol flags, only a reset clears them
  always_ff @(posedge rvfi_core) begin
    if (!rst_n_i) begin
      overflow_o  <= 1'b0;
      order_err_o <= 1'b0;
    end else begin
      // retirement lost, there is no back-pressure towards the core
      if (push_i && full && !pop_i) begin
        overflow_o <= 1'b1;
      end
      // reference model retired something the core never did
      if (pop_i && empty && !push_i) begin
        order_err_o <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/rvfi_field_compare.sv ====
// RVFI field comparator
// applies the masking rules to one core/reference retirement pair and
// registers a mismatch bit per field along with the core pc and insn

`timescale 1ns/1ns

module rvfi_field_compare (
  input  logic                       rvfi_core,
  input  logic                       rst_n_i,
  input  logic                       pair_valid_i,
  input  rvfi_cmp_pkg::rvfi_retire_t core_i,
  input  rvfi_cmp_pkg::rvfi_retire_t rm_i,
  output logic                       cmp_valid_o,
  output logic                       cmp_fail_o,
  output rvfi_cmp_pkg::cmp_mask_t    mismatch_o,
  output logic [31:0]                cmp_pc_o,
  output logic [31:0]                cmp_insn_o
);

  import rvfi_cmp_pkg::*;

  logic      multi_access;
  logic      any_trap;
  logic      core_mem_access;
  logic      mem_data_diff;
  cmp_mask_t mismatch_d;

  // a nonzero high nibble on either side means a split access
  assign multi_access = (|core_i.mem_rmask[7:4]) || (|core_i.mem_wmask[7:4]) ||
                        (|rm_i.mem_rmask[7:4])   || (|rm_i.mem_wmask[7:4]);

  assign any_trap = core_i.trap || rm_i.trap;

  assign core_mem_access = (|core_i.mem_rmask[3:0]) || (|core_i.mem_wmask[3:0]);

  // byte lanes enabled by the core masks only
  always_comb begin
    mem_data_diff = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (core_i.mem_wmask[i] &&
          (core_i.mem_wdata[i*8 +: 8] != rm_i.mem_wdata[i*8 +: 8])) begin
        mem_data_diff = 1'b1;
      end
      if (core_i.mem_rmask[i] &&
          (core_i.mem_rdata[i*8 +: 8] != rm_i.mem_rdata[i*8 +: 8])) begin
        mem_data_diff = 1'b1;
      end
    end
  end

  always_comb begin
    mismatch_d = '0;

    // control fields are checked on every retirement
    mismatch_d[F_PC]       = (core_i.pc_rdata != rm_i.pc_rdata);
    mismatch_d[F_INSN]     = (core_i.insn     != rm_i.insn);
    mismatch_d[F_TRAP]     = (core_i.trap     != rm_i.trap);
    mismatch_d[F_HALT]     = (core_i.halt     != rm_i.halt);
    mismatch_d[F_DBG]      = (core_i.dbg      != rm_i.dbg);
    mismatch_d[F_DBG_MODE] = (core_i.dbg_mode != rm_i.dbg_mode);
    mismatch_d[F_NMIP]     = (core_i.nmip     != rm_i.nmip);
    mismatch_d[F_INTR]     = (core_i.intr     != rm_i.intr);
    mismatch_d[F_MODE]     = (core_i.mode     != rm_i.mode);

    if (!multi_access) begin
      // rd results of a trapping instruction are not comparable
      if (!any_trap) begin
        mismatch_d[F_RD_ADDR] = (core_i.rd1_addr != rm_i.rd1_addr);
        // x0 writes may carry any data
        if (core_i.rd1_addr != 5'd0) begin
          mismatch_d[F_RD_WDATA] = (core_i.rd1_wdata != rm_i.rd1_wdata);
        end
      end

      mismatch_d[F_MEM_RMASK] = (core_i.mem_rmask[3:0] != rm_i.mem_rmask[3:0]);
      mismatch_d[F_MEM_WMASK] = (core_i.mem_wmask[3:0] != rm_i.mem_wmask[3:0]);

      // address only means something when the core actually accessed memory
      if (core_mem_access) begin
        mismatch_d[F_MEM_ADDR] = (core_i.mem_addr != rm_i.mem_addr);
      end

      mismatch_d[F_MEM_DATA] = mem_data_diff;
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (!rst_n_i) begin
      cmp_valid_o <= 1'b0;
      mismatch_o  <= '0;
    end else begin
      cmp_valid_o <= pair_valid_i;
      if (pair_valid_i) begin
        mismatch_o <= mismatch_d;
      end
    end
  end

  // identifies the failing instruction for the log
  always_ff @(posedge rvfi_core) begin
    if (pair_valid_i) begin
      cmp_pc_o   <= core_i.pc_rdata;
      cmp_insn_o <= core_i.insn;
    end
  end

  assign cmp_fail_o = cmp_valid_o && (|mismatch_o);

endmodule

// ==== rtl/rvfi_mismatch_log.sv ====
// RVFI mismatch log
// counts compared and failing retirements and keeps the first failure
// until the next reset

`timescale 1ns/1ns

module rvfi_mismatch_log #(
  parameter int unsigned CNT_W = 16
) (
  input  logic                     rvfi_core,
  input  logic                     rst_n_i,
  input  logic                     cmp_valid_i,
  input  logic                     cmp_fail_i,
  input  rvfi_cmp_pkg::cmp_mask_t  mismatch_i,
  input  logic [31:0]              cmp_pc_i,
  input  logic [31:0]              cmp_insn_i,
  output logic [CNT_W-1:0]         retire_count_o,
  output logic [CNT_W-1:0]         mismatch_count_o,
  output rvfi_cmp_pkg::mismatch_t  first_mismatch_o,
  output rvfi_cmp_pkg::log_state_e log_state_o
);

  import rvfi_cmp_pkg::*;

  log_state_e state_q;
  log_state_e state_d;

  logic fail;
  logic capture;

  assign fail = cmp_valid_i && cmp_fail_i;

  // only the first failing retirement is recorded
  assign capture = fail && (state_q == LOG_CLEAN);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOG_CLEAN: begin
        if (fail) begin
          state_d = LOG_FAILED;
        end
      end
      LOG_FAILED: begin
        state_d = LOG_FAILED;
      end
      default: begin
        state_d = LOG_CLEAN;
      end
    endcase
  end

  always_ff @(posedge rvfi_core) begin
    if (!rst_n_i) begin
      state_q <= LOG_CLEAN;
    end else begin
      state_q <= state_d;
    end
  end

  // counters stop at all ones instead of wrapping
  always_ff @(posedge rvfi_core) begin
    if (!rst_n_i) begin
      retire_count_o   <= '0;
      mismatch_count_o <= '0;
    end else begin
      if (cmp_valid_i && (retire_count_o != '1)) begin
        retire_count_o <= retire_count_o + 1'b1;
      end
      if (fail && (mismatch_count_o != '1)) begin
        mismatch_count_o <= mismatch_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (!rst_n_i) begin
      first_mismatch_o <= '0;
    end else if (capture) begin
      first_mismatch_o.pc   <= cmp_pc_i;
      first_mismatch_o.insn <= cmp_insn_i;
      first_mismatch_o.mask <= mismatch_i;
    end
  end

  assign log_state_o = state_q;

endmodule

// ==== rtl/rvfi_step_compare.sv ====
// RVFI step-and-compare checker
// pairs core retirements with the lagging reference model retirements,
// compares them field by field and logs the outcome

`timescale 1ns/1ns

module rvfi_step_compare #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned CNT_W = 16
) (
  input  logic                       rvfi_core,
  input  logic                       rst_n_i,
  input  logic                       core_valid_i,
  input  rvfi_cmp_pkg::rvfi_retire_t core_retire_i,
  input  logic                       rm_valid_i,
  input  rvfi_cmp_pkg::rvfi_retire_t rm_retire_i,
  output logic                       cmp_valid_o,
  output logic                       cmp_fail_o,
  output rvfi_cmp_pkg::cmp_mask_t    mismatch_o,
  output logic [CNT_W-1:0]           retire_count_o,
  output logic [CNT_W-1:0]           mismatch_count_o,
  output rvfi_cmp_pkg::mismatch_t    first_mismatch_o,
  output rvfi_cmp_pkg::log_state_e   log_state_o,
  output logic                       overflow_o,
  output logic                       order_err_o
);

  import rvfi_cmp_pkg::*;

  logic         pair_valid;
  rvfi_retire_t pair_core;
  logic [31:0]  cmp_pc;
  logic [31:0]  cmp_insn;

  // every rm strobe pops the oldest outstanding core retirement
  rvfi_retire_fifo #(
    .DEPTH (DEPTH)
  ) u_retire_fifo (
    .rvfi_core    (rvfi_core),
    .rst_n_i      (rst_n_i),
    .push_i       (core_valid_i),
    .push_data_i  (core_retire_i),
    .pop_i        (rm_valid_i),
    .pair_valid_o (pair_valid),
    .pair_data_o  (pair_core),
    .overflow_o   (overflow_o),
    .order_err_o  (order_err_o)
  );

  rvfi_field_compare u_field_compare (
    .rvfi_core    (rvfi_core),
    .rst_n_i      (rst_n_i),
    .pair_valid_i (pair_valid),
    .core_i       (pair_core),
    .rm_i         (rm_retire_i),
    .cmp_valid_o  (cmp_valid_o),
    .cmp_fail_o   (cmp_fail_o),
    .mismatch_o   (mismatch_o),
    .cmp_pc_o     (cmp_pc),
    .cmp_insn_o   (cmp_insn)
  );

  rvfi_mismatch_log #(
    .CNT_W (CNT_W)
  ) u_mismatch_log (
    .rvfi_core        (rvfi_core),
    .rst_n_i          (rst_n_i),
    .cmp_valid_i      (cmp_valid_o),
    .cmp_fail_i       (cmp_fail_o),
    .mismatch_i       (mismatch_o),
    .cmp_pc_i         (cmp_pc),
    .cmp_insn_i       (cmp_insn),
    .retire_count_o   (retire_count_o),
    .mismatch_count_o (mismatch_count_o),
    .first_mismatch_o (first_mismatch_o),
    .log_state_o      (log_state_o)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
// testbench clock and reset source
// 8 ns clock, reset held low for 4 cycles at start and after each restart

`timescale 1ns/1ns

module tb_clk_gen (
  input  logic restart_i,
  output logic clk_o,
  output logic rst_n_o
);

  int unsigned rst_cnt = 4;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  always @(posedge clk_o) begin
    if (restart_i) begin
      rst_cnt <= 4;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign rst_n_o = (rst_cnt == 0);

endmodule

// ==== testbench/tb_rvfi_checker.sv ====
// scoreboard for the step-and-compare checker
// keeps a pairing queue, the masking rules and counters of its own,
// and compares every DUT output on the falling edge

`timescale 1ns/1ns

module tb_rvfi_checker #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned CNT_W = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       core_valid_i,
  input  rvfi_cmp_pkg::rvfi_retire_t core_retire_i,
  input  logic                       rm_valid_i,
  input  rvfi_cmp_pkg::rvfi_retire_t rm_retire_i,
  input  logic                       cmp_valid_i,
  input  logic                       cmp_fail_i,
  input  rvfi_cmp_pkg::cmp_mask_t    mismatch_i,
  input  logic [CNT_W-1:0]           retire_count_i,
  input  logic [CNT_W-1:0]           mismatch_count_i,
  input  rvfi_cmp_pkg::mismatch_t    first_mismatch_i,
  input  rvfi_cmp_pkg::log_state_e   log_state_i,
  input  logic                       overflow_i,
  input  logic                       order_err_i,
  input  logic                       inj_valid_i,
  input  rvfi_cmp_pkg::cmp_field_e   inj_field_i,
  input  logic                       inj_hit_i,
  input  int                         phase_i,
  output int                         err_count_o
);

  import rvfi_cmp_pkg::*;

  rvfi_retire_t     pend_q [$];
  rvfi_retire_t     pair_rec;
  logic             seen_rst = 1'b0;
  logic             exp_valid;
  cmp_mask_t        exp_mask;
  logic [31:0]      exp_pc;
  logic [31:0]      exp_insn;
  logic [CNT_W-1:0] retire_cnt;
  logic [CNT_W-1:0] mism_cnt;
  mismatch_t        first_rec;
  logic             failed;
  logic             ovf;
  logic             ord;

  initial err_count_o = 0;

  function automatic string phase_name(input int p);
    case (p)
      1: return "identical_streams";
      2: return "control_corruption";
      3: return "masking";
      4: return "byte_lane_mem";
      5: return "protocol_faults";
      default: return "idle";
    endcase
  endfunction

  // masking rules applied to one pair
  function automatic cmp_mask_t rule_mask(input rvfi_retire_t c, input rvfi_retire_t r);
    cmp_mask_t m;
    logic      multi;
    m = '0;
    m[F_PC]       = c.pc_rdata != r.pc_rdata;
    m[F_INSN]     = c.insn != r.insn;
    m[F_TRAP]     = c.trap != r.trap;
    m[F_HALT]     = c.halt != r.halt;
    m[F_DBG]      = c.dbg != r.dbg;
    m[F_DBG_MODE] = c.dbg_mode != r.dbg_mode;
    m[F_NMIP]     = c.nmip != r.nmip;
    m[F_INTR]     = c.intr != r.intr;
    m[F_MODE]     = c.mode != r.mode;
    multi = (c.mem_rmask[7:4] != 0) || (c.mem_wmask[7:4] != 0) ||
            (r.mem_rmask[7:4] != 0) || (r.mem_wmask[7:4] != 0);
    if (!multi) begin
      if (!c.trap && !r.trap) begin
        m[F_RD_ADDR] = c.rd1_addr != r.rd1_addr;
        m[F_RD_WDATA] = (c.rd1_addr != 0) && (c.rd1_wdata != r.rd1_wdata);
      end
      m[F_MEM_RMASK] = c.mem_rmask[3:0] != r.mem_rmask[3:0];
      m[F_MEM_WMASK] = c.mem_wmask[3:0] != r.mem_wmask[3:0];
      if ((c.mem_rmask[3:0] != 0) || (c.mem_wmask[3:0] != 0)) begin
        m[F_MEM_ADDR] = c.mem_addr != r.mem_addr;
      end
      for (int b = 0; b < 4; b++) begin
        if (c.mem_wmask[b] && (c.mem_wdata[8*b +: 8] != r.mem_wdata[8*b +: 8])) begin
          m[F_MEM_DATA] = 1'b1;
        end
        if (c.mem_rmask[b] && (c.mem_rdata[8*b +: 8] != r.mem_rdata[8*b +: 8])) begin
          m[F_MEM_DATA] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  task automatic check_value(input string what, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
    if (exp_v !== act_v) begin
      $display("** Error [%s] %s: expected %0h, actual %0h",
               phase_name(phase_i), what, exp_v, act_v);
      err_count_o++;
    end
  endtask

  // model update on the same edge the DUT registers its inputs
  always @(posedge clk_i) begin
    logic bypassed;
    cmp_mask_t want;
    bypassed = 1'b0;
    if (!rst_n_i) begin
      pend_q.delete();
      exp_valid  = 1'b0;
      exp_mask   = '0;
      retire_cnt = '0;
      mism_cnt   = '0;
      first_rec  = '0;
      failed     = 1'b0;
      ovf        = 1'b0;
      ord        = 1'b0;
      seen_rst   = 1'b1;
    end else if (seen_rst) begin
      // log stage sees last cycle's compare result
      if (exp_valid) begin
        retire_cnt = retire_cnt + 1'b1;
        if (exp_mask != 0) begin
          mism_cnt = mism_cnt + 1'b1;
          if (!failed) begin
            failed    = 1'b1;
            first_rec = {exp_pc, exp_insn, exp_mask};
          end
        end
      end
      exp_valid = 1'b0;
      if (rm_valid_i) begin
        if (pend_q.size() > 0) begin
          pair_rec  = pend_q.pop_front();
          exp_valid = 1'b1;
        end else if (core_valid_i) begin
          pair_rec  = core_retire_i;
          exp_valid = 1'b1;
          bypassed  = 1'b1;
        end else begin
          ord = 1'b1;
        end
      end
      if (core_valid_i && !bypassed) begin
        if (pend_q.size() < DEPTH) begin
          pend_q.push_back(core_retire_i);
        end else begin
          ovf = 1'b1;
        end
      end
      if (exp_valid) begin
        exp_mask = rule_mask(pair_rec, rm_retire_i);
        exp_pc   = pair_rec.pc_rdata;
        exp_insn = pair_rec.insn;
        if (inj_valid_i) begin
          want = inj_hit_i ? (cmp_mask_t'(1) << inj_field_i) : '0;
          check_value("injected field mask", want, exp_mask);
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (seen_rst) begin
      check_value("cmp_valid_o", exp_valid, cmp_valid_i);
      if (exp_valid) begin
        check_value("mismatch_o", exp_mask, mismatch_i);
        check_value("cmp_fail_o", exp_mask != 0, cmp_fail_i);
      end else begin
        check_value("cmp_fail_o", 1'b0, cmp_fail_i);
      end
      check_value("retire_count_o", retire_cnt, retire_count_i);
      check_value("mismatch_count_o", mism_cnt, mismatch_count_i);
      check_value("first_mismatch_o", first_rec, first_mismatch_i);
      check_value("log_state_o", failed ? LOG_FAILED : LOG_CLEAN, log_state_i);
      check_value("overflow_o", ovf, overflow_i);
      check_value("order_err_o", ord, order_err_i);
    end
  end

endmodule

// ==== testbench/tb_rvfi_step_compare.sv ====
// testbench top for the step-and-compare checker
// random core retirements, lagging reference copies with injected faults,
// then the order error and overflow cases

`timescale 1ns/1ns

module tb_rvfi_step_compare;

  import rvfi_cmp_pkg::*;

  localparam int unsigned DEPTH = 4;
  localparam int unsigned CNT_W = 16;

  logic             clk;
  logic             rst_n;
  logic             restart;
  logic             core_valid;
  logic             rm_valid;
  rvfi_retire_t     core_ret;
  rvfi_retire_t     rm_ret;
  logic             inj_valid;
  logic             inj_hit;
  cmp_field_e       inj_field;
  int               phase;
  int               err_count;
  int               timeouts;
  logic             cmp_valid;
  logic             cmp_fail;
  cmp_mask_t        mismatch;
  logic [CNT_W-1:0] retire_count;
  logic [CNT_W-1:0] mismatch_count;
  mismatch_t        first_mismatch;
  log_state_e       log_state;
  logic             overflow;
  logic             order_err;
  logic [31:0]      lfsr;
  rvfi_retire_t     pend_q [$];
  int               case_q [$];

  tb_clk_gen u_clk_gen (.restart_i(restart), .clk_o(clk), .rst_n_o(rst_n));

  rvfi_step_compare #(.DEPTH(DEPTH), .CNT_W(CNT_W)) DUT (
    .rvfi_core(clk), .rst_n_i(rst_n),
    .core_valid_i(core_valid), .core_retire_i(core_ret),
    .rm_valid_i(rm_valid), .rm_retire_i(rm_ret),
    .cmp_valid_o(cmp_valid), .cmp_fail_o(cmp_fail), .mismatch_o(mismatch),
    .retire_count_o(retire_count), .mismatch_count_o(mismatch_count),
    .first_mismatch_o(first_mismatch), .log_state_o(log_state),
    .overflow_o(overflow), .order_err_o(order_err)
  );

  tb_rvfi_checker #(.DEPTH(DEPTH), .CNT_W(CNT_W)) u_checker (
    .clk_i(clk), .rst_n_i(rst_n),
    .core_valid_i(core_valid), .core_retire_i(core_ret),
    .rm_valid_i(rm_valid), .rm_retire_i(rm_ret),
    .cmp_valid_i(cmp_valid), .cmp_fail_i(cmp_fail), .mismatch_i(mismatch),
    .retire_count_i(retire_count), .mismatch_count_i(mismatch_count),
    .first_mismatch_i(first_mismatch), .log_state_i(log_state),
    .overflow_i(overflow), .order_err_i(order_err),
    .inj_valid_i(inj_valid), .inj_field_i(inj_field), .inj_hit_i(inj_hit),
    .phase_i(phase), .err_count_o(err_count)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic rvfi_retire_t gen_retire(input int ph, input int kase);
    rvfi_retire_t r;
    r.pc_rdata  = rand_bits(32);
    r.insn      = rand_bits(32);
    r.trap      = 1'(rand_bits(1));
    r.halt      = 1'(rand_bits(1));
    r.dbg_mode  = 1'(rand_bits(1));
    r.dbg       = 3'(rand_bits(3));
    r.nmip      = 2'(rand_bits(2));
    r.intr      = 1'(rand_bits(1));
    r.mode      = 2'(rand_bits(2));
    r.rd1_addr  = 5'(rand_bits(5));
    r.rd1_wdata = rand_bits(32);
    r.mem_addr  = rand_bits(32);
    r.mem_rmask = {4'h0, 4'(rand_bits(4))};
    r.mem_wmask = {4'h0, 4'(rand_bits(4))};
    r.mem_rdata = rand_bits(32);
    r.mem_wdata = rand_bits(32);
    if (ph == 3) begin
      case (kase)
        0: begin
          r.rd1_addr = 5'd0;
          r.trap     = 1'b0;
        end
        1: r.trap = 1'b1;
        2: begin
          r.mem_rmask = 8'h03;
          r.mem_wmask = 8'h03;
        end
        default: r.mem_rmask[7:4] = 4'h5;
      endcase
    end else if (ph == 4) begin
      case (kase)
        0: begin
          r.mem_rmask = 8'h01;
          r.mem_wmask = 8'h00;
        end
        1: begin
          r.mem_rmask = 8'h00;
          r.mem_wmask = 8'h00;
        end
        2: begin
          r.mem_rmask = 8'h00;
          r.mem_wmask = 8'h0c;
        end
        default: begin
          r.mem_rmask = 8'h00;
          r.mem_wmask = 8'h04;
        end
      endcase
    end
    return r;
  endfunction

  // drives rm_ret from a core entry and corrupts it as the phase asks
  task automatic drive_rm(input rvfi_retire_t c, input int kase);
    logic [31:0] x;
    int          f;
    x = rand_bits(32) | 32'h0101_0101;
    rm_ret   = c;
    rm_valid = 1'b1;
    if (phase == 2 && rand_bits(2) != 0) begin
      f = rand_bits(4) % 13;
      inj_valid = 1'b1;
      inj_hit   = 1'b1;
      inj_field = cmp_field_e'(f);
      case (f)
        0: rm_ret.pc_rdata = c.pc_rdata ^ x;
        1: rm_ret.insn = c.insn ^ x;
        2: rm_ret.trap = ~c.trap;
        3: rm_ret.halt = ~c.halt;
        4: rm_ret.dbg = c.dbg ^ x[2:0];
        5: rm_ret.dbg_mode = ~c.dbg_mode;
        6: rm_ret.nmip = c.nmip ^ x[1:0];
        7: rm_ret.intr = ~c.intr;
        8: rm_ret.mode = c.mode ^ x[1:0];
        // rd fields count only on a retirement that does not trap
        9: begin
          rm_ret.rd1_addr = c.rd1_addr ^ x[4:0];
          inj_hit = !c.trap;
        end
        10: begin
          rm_ret.rd1_wdata = c.rd1_wdata ^ x;
          inj_hit = !c.trap && (c.rd1_addr != 5'd0);
        end
        11: rm_ret.mem_rmask[3:0] = c.mem_rmask[3:0] ^ x[3:0];
        default: rm_ret.mem_wmask[3:0] = c.mem_wmask[3:0] ^ x[3:0];
      endcase
    end else if (phase == 3) begin
      inj_valid = 1'b1;
      inj_hit   = 1'b0;
      case (kase)
        0: begin
          inj_field = F_RD_WDATA;
          rm_ret.rd1_wdata = c.rd1_wdata ^ x;
        end
        1: begin
          inj_field = F_RD_ADDR;
          rm_ret.rd1_addr  = c.rd1_addr ^ x[4:0];
          rm_ret.rd1_wdata = c.rd1_wdata ^ x;
        end
        2: begin
          inj_field = F_MEM_DATA;
          rm_ret.mem_rdata[31:16] = c.mem_rdata[31:16] ^ x[15:0];
          rm_ret.mem_wdata[31:24] = c.mem_wdata[31:24] ^ x[7:0];
        end
        default: begin
          inj_field = F_MEM_ADDR;
          rm_ret.mem_addr  = c.mem_addr ^ x;
          rm_ret.rd1_wdata = c.rd1_wdata ^ x;
          rm_ret.mem_wdata = c.mem_wdata ^ x;
        end
      endcase
    end else if (phase == 4) begin
      inj_valid = 1'b1;
      case (kase)
        0: begin
          inj_field = F_MEM_DATA;
          inj_hit   = 1'b1;
          rm_ret.mem_rdata[7:0] ^= x[7:0];
        end
        1: begin
          inj_field = F_MEM_ADDR;
          inj_hit   = 1'b0;
          rm_ret.mem_addr ^= x;
        end
        2: begin
          inj_field = F_MEM_ADDR;
          inj_hit   = 1'b1;
          rm_ret.mem_addr ^= x;
        end
        default: begin
          inj_field = F_MEM_DATA;
          inj_hit   = 1'b1;
          rm_ret.mem_wdata[23:16] ^= x[7:0];
        end
      endcase
    end
  endtask

  task automatic clear_inputs();
    core_valid = 1'b0;
    rm_valid   = 1'b0;
    inj_valid  = 1'b0;
    inj_hit    = 1'b0;
    inj_field  = F_PC;
  endtask

  // n core retirements with each copied to the reference side after a random lag
  task automatic run_phase(input int ph, input int n);
    int pushed;
    int cycles;
    logic just_pushed;
    phase  = ph;
    pushed = 0;
    cycles = 0;
    while ((pushed < n || pend_q.size() > 0) && cycles < n * 20) begin
      @(negedge clk);
      cycles++;
      clear_inputs();
      just_pushed = 1'b0;
      if (pend_q.size() > 0 && (pend_q.size() >= 3 || rand_bits(1))) begin
        drive_rm(pend_q.pop_front(), case_q.pop_front());
      end
      if (pushed < n && pend_q.size() < 3 && rand_bits(1)) begin
        case_q.push_back(int'(rand_bits(2)));
        core_ret = gen_retire(ph, case_q[$]);
        pend_q.push_back(core_ret);
        core_valid  = 1'b1;
        just_pushed = 1'b1;
        pushed++;
      end
      // zero lag goes through the fifo bypass
      if (!rm_valid && just_pushed && pend_q.size() == 1 && rand_bits(2) == 0) begin
        drive_rm(pend_q.pop_front(), case_q.pop_front());
      end
    end
    if (pend_q.size() > 0 || pushed < n) begin
      $display("phase %0d did not finish issuing its retirements in time", ph);
      timeouts++;
    end
    @(negedge clk);
    clear_inputs();
    repeat (3) @(negedge clk);
  endtask

  task automatic do_reset();
    int cycles;
    @(negedge clk);
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    cycles = 0;
    while (!rst_n && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("reset did not release in time");
      timeouts++;
    end
  endtask

  task automatic wait_flag(input int which, input string what);
    int cycles;
    cycles = 0;
    while (((which == 0) ? !order_err : !overflow) && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if ((which == 0) ? !order_err : !overflow) begin
      $display("%s flag never rose", what);
      timeouts++;
    end
  endtask

  initial begin
    #2_000_000;
    $display("simulation watchdog expired before the tests ended");
    $display("tests failed");
    $finish;
  end

  initial begin
    lfsr     = 32'h3b28_8737;
    restart  = 1'b0;
    phase    = 0;
    timeouts = 0;
    core_ret = '0;
    rm_ret   = '0;
    clear_inputs();
    do_reset();
    run_phase(1, 60);
    run_phase(2, 60);
    run_phase(3, 60);
    run_phase(4, 60);
    phase = 5;
    do_reset();
    @(negedge clk);
    rm_ret   = gen_retire(1, 0);
    rm_valid = 1'b1;
    @(negedge clk);
    clear_inputs();
    wait_flag(0, "order error");
    repeat (4) @(negedge clk);
    do_reset();
    repeat (5) begin
      @(negedge clk);
      core_ret   = gen_retire(1, 0);
      core_valid = 1'b1;
    end
    @(negedge clk);
    clear_inputs();
    wait_flag(1, "overflow");
    repeat (4) @(negedge clk);
    do_reset();
    repeat (4) @(negedge clk);
    $display("checker errors: %0d, timeouts: %0d", err_count, timeouts);
    if (err_count == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/rvfi_cmp_pkg.sv
rtl/rvfi_retire_fifo.sv
rtl/rvfi_field_compare.sv
rtl/rvfi_mismatch_log.sv
rtl/rvfi_step_compare.sv
testbench/tb_clk_gen.sv
testbench/tb_rvfi_checker.sv
testbench/tb_rvfi_step_compare.sv
